//--- Bender.yml
package:
  name: id_stage

sources:
  # RTL in compile order
  - hw/id_pkg.sv
  - hw/id_bundle_if.sv
  - hw/instr_decoder.sv
  - hw/id_ex_buffer.sv
  - hw/operand_fetch.sv
  - hw/id_stage_top.sv

  # Testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_id_stage.sv

//--- hw/id_bundle_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction bundle with valid/ready handshake
interface id_bundle_if import id_pkg::*; ();

  // Handshake
  logic                  valid;
  logic                  ready;

  // Decoded controls
  alu_op_e               alu_op;
  op_a_sel_e             op_a_sel;
  op_b_sel_e             op_b_sel;
  tgt_sel_e              tgt_sel;

  // Immediate and register indices
  logic [XLEN-1:0]       imm;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;

  // Flags and instruction address
  logic                  rf_we;
  logic                  lsu_en;
  logic                  lsu_we;
  logic                  illegal;
  logic [XLEN-1:0]       pc;

  // Producer side, consumer answers with ready
  modport src (
    output valid, alu_op, op_a_sel, op_b_sel, tgt_sel, imm, rs1, rs2, rd,
    output rf_we, lsu_en, lsu_we, illegal, pc,
    input  ready
  );

  modport dst (
    input  valid, alu_op, op_a_sel, op_b_sel, tgt_sel, imm, rs1, rs2, rd,
    input  rf_we, lsu_en, lsu_we, illegal, pc,
    output ready
  );

endinterface

`default_nettype wire

//--- hw/id_ex_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_buffer import id_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  id_bundle_if.dst up_i,
  id_bundle_if.src dn_o
);

  // One stored instruction
  typedef struct packed {
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    op_b_sel_e             op_b_sel;
    tgt_sel_e              tgt_sel;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic                  lsu_en;
    logic                  lsu_we;
    logic                  illegal;
    logic [XLEN-1:0]       pc;
  } entry_t;

  entry_t     mem [2];
  entry_t     wr_entry;
  entry_t     head;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_d;
  logic       full_q;
  logic       push;
  logic       pop;

  assign push = up_i.valid & up_i.ready;
  assign pop  = dn_o.valid & dn_o.ready;

  // Ready from a flop, low only with both slots taken
  assign up_i.ready = ~full_q;
  assign dn_o.valid = (count_q != 2'd0);

  always_comb begin
    case ({push, pop})
      2'b10:   count_d = count_q + 2'd1;
      2'b01:   count_d = count_q - 2'd1;
      default: count_d = count_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      full_q   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_d;
      full_q  <= (count_d == 2'd2);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= wr_entry;
    end
  end

  // Pack the incoming bundle
  assign wr_entry.alu_op   = up_i.alu_op;
  assign wr_entry.op_a_sel = up_i.op_a_sel;
  assign wr_entry.op_b_sel = up_i.op_b_sel;
  assign wr_entry.tgt_sel  = up_i.tgt_sel;
  assign wr_entry.imm      = up_i.imm;
  assign wr_entry.rs1      = up_i.rs1;
  assign wr_entry.rs2      = up_i.rs2;
  assign wr_entry.rd       = up_i.rd;
  assign wr_entry.rf_we    = up_i.rf_we;
  assign wr_entry.lsu_en   = up_i.lsu_en;
  assign wr_entry.lsu_we   = up_i.lsu_we;
  assign wr_entry.illegal  = up_i.illegal;
  assign wr_entry.pc       = up_i.pc;

  // Oldest entry drives the downstream bundle
  assign head           = mem[rd_ptr_q];
  assign dn_o.alu_op    = head.alu_op;
  assign dn_o.op_a_sel  = head.op_a_sel;
  assign dn_o.op_b_sel  = head.op_b_sel;
  assign dn_o.tgt_sel   = head.tgt_sel;
  assign dn_o.imm       = head.imm;
  assign dn_o.rs1       = head.rs1;
  assign dn_o.rs2       = head.rs2;
  assign dn_o.rd        = head.rd;
  assign dn_o.rf_we     = head.rf_we;
  assign dn_o.lsu_en    = head.lsu_en;
  assign dn_o.lsu_we    = head.lsu_we;
  assign dn_o.illegal   = head.illegal;
  assign dn_o.pc        = head.pc;

endmodule

`default_nettype wire

//--- hw/id_pkg.sv
`default_nettype none

package id_pkg;

  // Datapath and register file sizes
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // Link value written by JAL and JALR
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  // Field positions in the 32-bit instruction word
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  // RV32I major opcodes handled by the decoder
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD   = 7'h03,
    OPC_OPIMM  = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JALR   = 7'h67,
    OPC_JAL    = 7'h6f
  } opcode_e;

  // ALU operations, encoding follows funct3 order
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  // Operand B source
  typedef enum logic [1:0] {
    OP_B_REG    = 2'd0,
    OP_B_IMM    = 2'd1,
    OP_B_PCINCR = 2'd2
  } op_b_sel_e;

  // Control-transfer target, JALR clears bit 0
  typedef enum logic [1:0] {
    TGT_NONE    = 2'd0,
    TGT_PC_IMM  = 2'd1,
    TGT_RS1_IMM = 2'd2
  } tgt_sel_e;

endpackage

`default_nettype wire

//--- hw/id_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_top import id_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // Instruction input
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  instr_ready_o,
  // Register file write port
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       rf_wdata_i,
  // Decoded instruction with operands
  output logic                  out_valid_o,
  output alu_op_e               alu_op_o,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       store_data_o,
  output logic [XLEN-1:0]       target_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic                  rf_we_o,
  output logic                  lsu_en_o,
  output logic                  lsu_we_o,
  output logic                  illegal_o,
  input  logic                  out_ready_i
);

  // Decoder to buffer, buffer to operand fetch
  id_bundle_if dec_bus ();
  id_bundle_if exe_bus ();

  instr_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .dec_o         (dec_bus.src)
  );

  // Two-entry ID/EX register stage
  id_ex_buffer u_buffer (
    .clk   (clk),
    .rst_n (rst_n),
    .up_i  (dec_bus.dst),
    .dn_o  (exe_bus.src)
  );

  operand_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_i       (exe_bus.dst),
    .rf_we_i      (rf_we_i),
    .rf_waddr_i   (rf_waddr_i),
    .rf_wdata_i   (rf_wdata_i),
    .out_valid_o  (out_valid_o),
    .alu_op_o     (alu_op_o),
    .operand_a_o  (operand_a_o),
    .operand_b_o  (operand_b_o),
    .store_data_o (store_data_o),
    .target_o     (target_o),
    .rd_o         (rd_o),
    .rf_we_o      (rf_we_o),
    .lsu_en_o     (lsu_en_o),
    .lsu_we_o     (lsu_we_o),
    .illegal_o    (illegal_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import id_pkg::*; (
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  output logic            instr_ready_o,
  id_bundle_if.src        dec_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;

  // Sign-extended immediates, one per format
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;

  // Raw decode results before illegal masking
  alu_op_e         alu_op;
  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  tgt_sel_e        tgt_sel;
  logic [XLEN-1:0] imm;
  logic            rf_we;
  logic            lsu_en;
  logic            lsu_we;
  logic            illegal;

  // funct3 to ALU op, alt is instr[30]
  // SUB only exists for register-register ops
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                         input logic is_op);
    case (f3)
      3'b000:  alu_decode = (alt && is_op) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_decode = ALU_SLL;
      3'b010:  alu_decode = ALU_SLT;
      3'b011:  alu_decode = ALU_SLTU;
      3'b100:  alu_decode = ALU_XOR;
      3'b101:  alu_decode = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_decode = ALU_OR;
      default: alu_decode = ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(instr_i[OPCODE_W-1:0]);
  assign funct3 = instr_i[FUNCT3_LSB +: 3];
  assign funct7 = instr_i[FUNCT7_LSB +: 7];

  ////////////////////////////////////////////////////////////////////////////
  // Immediate generation
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  // B and J formats are halfword offsets
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults match a register-register op with no side effects
    alu_op   = ALU_ADD;
    op_a_sel = OP_A_REG;
    op_b_sel = OP_B_REG;
    tgt_sel  = TGT_NONE;
    imm      = imm_i_type;
    rf_we    = 1'b0;
    lsu_en   = 1'b0;
    lsu_we   = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op = alu_decode(funct3, funct7[5], 1'b1);
        rf_we  = 1'b1;
        // funct7 0x20 valid for SUB and SRA only
        if (funct7 == 7'h20) begin
          illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        end else begin
          illegal = (funct7 != 7'h00);
        end
      end
      OPC_OPIMM: begin
        alu_op   = alu_decode(funct3, funct7[5], 1'b0);
        op_b_sel = OP_B_IMM;
        rf_we    = 1'b1;
      end
      OPC_LUI: begin
        op_a_sel = OP_A_ZERO;
        op_b_sel = OP_B_IMM;
        imm      = imm_u_type;
        rf_we    = 1'b1;
      end
      OPC_AUIPC: begin
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_IMM;
        imm      = imm_u_type;
        rf_we    = 1'b1;
      end
      // Jumps compute the link value PC + 4 in the ALU
      OPC_JAL: begin
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_PCINCR;
        tgt_sel  = TGT_PC_IMM;
        imm      = imm_j_type;
        rf_we    = 1'b1;
      end
      OPC_JALR: begin
        op_a_sel = OP_A_PC;
        op_b_sel = OP_B_PCINCR;
        tgt_sel  = TGT_RS1_IMM;
        rf_we    = 1'b1;
      end
      OPC_BRANCH: begin
        // Compare op from funct3[2:1]
        case (funct3[2:1])
          2'b10:   alu_op = ALU_SLT;
          2'b11:   alu_op = ALU_SLTU;
          default: alu_op = ALU_SUB;
        endcase
        tgt_sel = TGT_PC_IMM;
        imm     = imm_b_type;
      end
      OPC_LOAD: begin
        op_b_sel = OP_B_IMM;
        rf_we    = 1'b1;
        lsu_en   = 1'b1;
      end
      OPC_STORE: begin
        op_b_sel = OP_B_IMM;
        imm      = imm_s_type;
        lsu_en   = 1'b1;
        lsu_we   = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Bundle outputs, pass-through handshake
  assign dec_o.valid    = instr_valid_i;
  assign instr_ready_o  = dec_o.ready;
  assign dec_o.alu_op   = alu_op;
  assign dec_o.op_a_sel = op_a_sel;
  assign dec_o.op_b_sel = op_b_sel;
  assign dec_o.tgt_sel  = tgt_sel;
  assign dec_o.imm      = imm;
  assign dec_o.rs1      = instr_i[RS1_LSB +: REG_ADDR_W];
  assign dec_o.rs2      = instr_i[RS2_LSB +: REG_ADDR_W];
  assign dec_o.rd       = instr_i[RD_LSB +: REG_ADDR_W];
  // Illegal instructions must not write anything
  assign dec_o.rf_we    = rf_we & ~illegal;
  assign dec_o.lsu_en   = lsu_en & ~illegal;
  assign dec_o.lsu_we   = lsu_we & ~illegal;
  assign dec_o.illegal  = illegal;
  assign dec_o.pc       = pc_i;

endmodule

`default_nettype wire

//--- hw/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import id_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  id_bundle_if.dst              head_i,
  // Register file write port
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic [XLEN-1:0]       rf_wdata_i,
  // Results towards execute
  output logic                  out_valid_o,
  output alu_op_e               alu_op_o,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       store_data_o,
  output logic [XLEN-1:0]       target_o,
  output logic [REG_ADDR_W-1:0] rd_o,
  output logic                  rf_we_o,
  output logic                  lsu_en_o,
  output logic                  lsu_we_o,
  output logic                  illegal_o,
  input  logic                  out_ready_i
);

  logic [XLEN-1:0] rf_q [NUM_REGS];
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] jalr_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////////////////////

  // x0 never written, so it reads zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_we_i && (rf_waddr_i != '0)) begin
      rf_q[rf_waddr_i] <= rf_wdata_i;
    end
  end

  // Read ports for the buffer head
  assign rs1_val = rf_q[head_i.rs1];
  assign rs2_val = rf_q[head_i.rs2];

  ////////////////////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (head_i.op_a_sel)
      OP_A_PC:   operand_a_o = head_i.pc;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_val;
    endcase
  end

  always_comb begin
    case (head_i.op_b_sel)
      OP_B_IMM:    operand_b_o = head_i.imm;
      OP_B_PCINCR: operand_b_o = PC_INCR;
      default:     operand_b_o = rs2_val;
    endcase
  end

  // Stores take their data from rs2
  assign store_data_o = rs2_val;

  // Jump and branch target
  assign jalr_sum = rs1_val + head_i.imm;

  always_comb begin
    case (head_i.tgt_sel)
      TGT_PC_IMM:  target_o = head_i.pc + head_i.imm;
      // JALR target has bit 0 forced low
      TGT_RS1_IMM: target_o = {jalr_sum[XLEN-1:1], 1'b0};
      default:     target_o = '0;
    endcase
  end

  // Remaining fields go straight through
  assign out_valid_o  = head_i.valid;
  assign head_i.ready = out_ready_i;
  assign alu_op_o     = head_i.alu_op;
  assign rd_o         = head_i.rd;
  assign rf_we_o      = head_i.rf_we;
  assign lsu_en_o     = head_i.lsu_en;
  assign lsu_we_o     = head_i.lsu_we;
  assign illegal_o    = head_i.illegal;

endmodule

`default_nettype wire

//--- sources.f
+incdir+tb
hw/id_pkg.sv
hw/id_bundle_if.sv
hw/instr_decoder.sv
hw/id_ex_buffer.sv
hw/operand_fetch.sv
hw/id_stage_top.sv
tb/tb_id_stage.sv

//--- tb/tb_id_model.svh
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// Expected DUT outputs for one instruction
typedef struct packed {
  alu_op_e     alu_op;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] store_data;
  logic [31:0] target;
  logic [4:0]  rd;
  logic        rf_we;
  logic        lsu_en;
  logic        lsu_we;
  logic        illegal;
} expect_t;

////////////////////////////////////////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  r_type = {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
  i_type = {imm, rs1, f3, rd, opc};
endfunction

// Store offset split around the rs fields
function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

// Branch offset, bit 0 is implied
function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  b_type = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

////////////////////////////////////////////////////////////////////////////
// Reference decode
////////////////////////////////////////////////////////////////////////////

// ALU op by funct3, alt marks SUB or SRA
function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    alu_from_funct3 = alt ? ALU_SUB : ALU_ADD;
    3'd1:    alu_from_funct3 = ALU_SLL;
    3'd2:    alu_from_funct3 = ALU_SLT;
    3'd3:    alu_from_funct3 = ALU_SLTU;
    3'd4:    alu_from_funct3 = ALU_XOR;
    3'd5:    alu_from_funct3 = alt ? ALU_SRA : ALU_SRL;
    3'd6:    alu_from_funct3 = ALU_OR;
    default: alu_from_funct3 = ALU_AND;
  endcase
endfunction

function automatic expect_t id_ref(input logic [31:0] instr, input logic [31:0] pc,
                                   input logic [31:0][31:0] regs);
  expect_t     e;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [2:0]  f3;
  logic [6:0]  f7;
  f3    = instr[14:12];
  f7    = instr[31:25];
  // All signed formats share the sign run of the I immediate
  imm_i = $signed(instr) >>> 20;
  imm_s = {imm_i[31:5], instr[11:7]};
  imm_b = {imm_i[31:12], instr[7], instr[30:25], instr[11:8], 1'b0};
  imm_u = {instr[31:12], 12'h000};
  imm_j = {imm_i[31:20], instr[19:12], instr[20], instr[30:21], 1'b0};
  // Register-register defaults
  e.alu_op     = ALU_ADD;
  e.op_a       = regs[instr[19:15]];
  e.op_b       = regs[instr[24:20]];
  e.store_data = regs[instr[24:20]];
  e.target     = 32'h0;
  e.rd         = instr[11:7];
  e.rf_we      = 1'b0;
  e.lsu_en     = 1'b0;
  e.lsu_we     = 1'b0;
  e.illegal    = 1'b0;
  case (instr[6:0])
    7'h33: begin
      e.alu_op  = alu_from_funct3(f3, instr[30]);
      e.rf_we   = 1'b1;
      e.illegal = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
    end
    7'h13: begin
      // Only SRAI uses bit 30
      e.alu_op = alu_from_funct3(f3, (f3 == 3'd5) && instr[30]);
      e.op_b   = imm_i;
      e.rf_we  = 1'b1;
    end
    7'h37: begin
      e.op_a  = 32'h0;
      e.op_b  = imm_u;
      e.rf_we = 1'b1;
    end
    7'h17: begin
      e.op_a  = pc;
      e.op_b  = imm_u;
      e.rf_we = 1'b1;
    end
    // Link value is PC + 4
    7'h6f: begin
      e.op_a   = pc;
      e.op_b   = 32'd4;
      e.target = pc + imm_j;
      e.rf_we  = 1'b1;
    end
    7'h67: begin
      e.op_a   = pc;
      e.op_b   = 32'd4;
      e.target = (regs[instr[19:15]] + imm_i) & 32'hffff_fffe;
      e.rf_we  = 1'b1;
    end
    7'h63: begin
      // BEQ/BNE subtract, BLT/BGE signed, BLTU/BGEU unsigned
      e.alu_op = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
      e.target = pc + imm_b;
    end
    7'h03: begin
      e.op_b   = imm_i;
      e.rf_we  = 1'b1;
      e.lsu_en = 1'b1;
    end
    7'h23: begin
      e.op_b   = imm_s;
      e.lsu_en = 1'b1;
      e.lsu_we = 1'b1;
    end
    default: e.illegal = 1'b1;
  endcase
  // Nothing is written for an illegal instruction
  if (e.illegal) begin
    e.rf_we  = 1'b0;
    e.lsu_en = 1'b0;
    e.lsu_we = 1'b0;
  end
  id_ref = e;
endfunction

`endif

//--- tb/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  `include "tb_id_model.svh"

  // Instructions per test
  localparam int N_ALU   = 48;
  localparam int N_UPPER = 16;
  localparam int N_CTRL  = 20;
  localparam int N_MEM   = 24;
  localparam int N_MIX   = 200;
  localparam int LIMIT   = 20 * (N_ALU + N_UPPER + N_CTRL + N_MEM + N_MIX);
  localparam logic [31:0] PC_MASK = 32'hffff_fffc;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid_i;
  logic [XLEN-1:0]       instr_i;
  logic [XLEN-1:0]       pc_i;
  logic                  instr_ready_o;
  logic                  rf_we_i;
  logic [REG_ADDR_W-1:0] rf_waddr_i;
  logic [XLEN-1:0]       rf_wdata_i;
  logic                  out_valid_o;
  alu_op_e               alu_op_o;
  logic [XLEN-1:0]       operand_a_o;
  logic [XLEN-1:0]       operand_b_o;
  logic [XLEN-1:0]       store_data_o;
  logic [XLEN-1:0]       target_o;
  logic [REG_ADDR_W-1:0] rd_o;
  logic                  rf_we_o;
  logic                  lsu_en_o;
  logic                  lsu_we_o;
  logic                  illegal_o;
  logic                  out_ready_i;

  int                seed = 32'hab24_cab0;
  logic [31:0][31:0] mirror;
  expect_t           exp_q[$];
  int                errors;
  int                checks;
  int                tests_run;
  int                cycles;
  // Occupancy the buffer should have as seen from the handshakes
  int                level;
  bit                mix_mode;

  id_stage_top dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .rf_we_i       (rf_we_i),
    .rf_waddr_i    (rf_waddr_i),
    .rf_wdata_i    (rf_wdata_i),
    .out_valid_o   (out_valid_o),
    .alu_op_o      (alu_op_o),
    .operand_a_o   (operand_a_o),
    .operand_b_o   (operand_b_o),
    .store_data_o  (store_data_o),
    .target_o      (target_o),
    .rd_o          (rd_o),
    .rf_we_o       (rf_we_o),
    .lsu_en_o      (lsu_en_o),
    .lsu_we_o      (lsu_we_o),
    .illegal_o     (illegal_o),
    .out_ready_i   (out_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Legal instruction of one class with its fields taken from r
  function automatic logic [31:0] rand_instr(input int cls, input logic [31:0] r);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = r[14:12];
    f7 = (r[30] && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
    case (cls)
      0: rand_instr = {f7, r[24:7], 7'h33};
      // Shift immediates keep bits 31 and 29:25 clear
      1: rand_instr = (r[13:12] == 2'b01) ? {1'b0, r[30] & r[14], 5'b0, r[24:7], 7'h13}
                                          : {r[31:7], 7'h13};
      2: rand_instr = {r[31:7], 7'h37};
      3: rand_instr = {r[31:7], 7'h17};
      4: rand_instr = {r[31:7], 7'h6f};
      5: rand_instr = {r[31:15], 3'b000, r[11:7], 7'h67};
      // funct3 2 and 3 are no branch and move to 6 and 7
      6: rand_instr = {r[31:15], f3 | {f3[1] & ~f3[2], 2'b00}, r[11:7], 7'h63};
      default: rand_instr = {r[31:7], r[0] ? 7'h23 : 7'h03};
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk);
    rf_we_i    <= 1'b1;
    rf_waddr_i <= addr;
    rf_wdata_i <= data;
    // x0 stays zero
    if (addr != 5'd0) begin
      mirror[addr] = data;
    end
    @(posedge clk);
    rf_we_i <= 1'b0;
  endtask

  task automatic preload_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      write_reg(r[4:0], $random(seed));
    end
  endtask

  // Hold valid until accepted and queue the expectation at issue
  task automatic send(input logic [31:0] instr, input logic [31:0] pc, input int gap);
    bit acc;
    repeat (gap) begin
      @(posedge clk);
      instr_valid_i <= 1'b0;
    end
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= instr;
    pc_i          <= pc;
    exp_q.push_back(id_ref(instr, pc, mirror));
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = instr_ready_o;
    end
  endtask

  // Stop input and drain the stage
  task automatic close_test(input string name, input int start);
    @(posedge clk);
    instr_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    @(posedge clk);
    $display("Test %s done, %0d errors", name, errors - start);
    tests_run++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output checking
  ////////////////////////////////////////////////////////////////////////////

  // Random back-pressure during the mix test only
  always @(posedge clk) begin
    if (mix_mode) begin
      out_ready_i <= ($random(seed) & 3) != 0;
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  // Sampled mid-cycle where inputs and outputs are settled
  always @(negedge clk) begin : compare_outputs
    expect_t e;
    if (rst_n) begin
      if (instr_ready_o !== (level != 2)) begin
        $display("[ERROR] %0t: instr_ready_o is %b with %0d pending", $time,
                 instr_ready_o, level);
        errors++;
      end
      if (out_valid_o !== (level != 0)) begin
        $display("[ERROR] %0t: out_valid_o is %b with %0d pending", $time,
                 out_valid_o, level);
        errors++;
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output at %0t with no instruction outstanding", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          check_word("illegal_o", illegal_o, e.illegal);
          check_word("rf_we_o", rf_we_o, e.rf_we);
          check_word("lsu_en_o", lsu_en_o, e.lsu_en);
          check_word("lsu_we_o", lsu_we_o, e.lsu_we);
          // Operands of an illegal instruction are don't care
          if (!e.illegal) begin
            check_word("alu_op_o", alu_op_o, e.alu_op);
            check_word("operand_a_o", operand_a_o, e.op_a);
            check_word("operand_b_o", operand_b_o, e.op_b);
            check_word("store_data_o", store_data_o, e.store_data);
            check_word("target_o", target_o, e.target);
            check_word("rd_o", rd_o, e.rd);
          end
        end
      end
      // Handshakes seen now take effect at the next edge
      level = level + int'(instr_valid_i && instr_ready_o) - int'(out_valid_o && out_ready_i);
    end
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the stage stopped making progress", LIMIT);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          start;
    int          k;
    logic [31:0] r;
    logic [6:0]  opc;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    rf_we_i       = 1'b0;
    rf_waddr_i    = '0;
    rf_wdata_i    = '0;
    out_ready_i   = 1'b1;
    mirror        = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (out_valid_o !== 1'b0 || instr_ready_o !== 1'b1) begin
      $display("[ERROR] %0t: after reset out_valid_o=%b instr_ready_o=%b", $time,
               out_valid_o, instr_ready_o);
      errors++;
    end

    // ALU ops starting with reads of x0
    start = errors;
    preload_regs();
    send(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd3), $random(seed) & PC_MASK, 0);
    send(i_type(12'h7ff, 5'd0, 3'd0, 5'd4, 7'h13), $random(seed) & PC_MASK, 0);
    for (int i = 0; i < N_ALU - 2; i++) begin
      send(rand_instr(i % 2, $random(seed)), $random(seed) & PC_MASK, 0);
    end
    close_test("alu", start);

    // LUI and AUIPC
    start = errors;
    for (int i = 0; i < N_UPPER; i++) begin
      send(rand_instr(2 + i % 2, $random(seed)), $random(seed) & PC_MASK, 0);
    end
    close_test("upper", start);

    // Jumps and then the six branches twice
    start = errors;
    for (int i = 0; i < N_CTRL; i++) begin
      r = $random(seed);
      k = (i - 8) % 6;
      if (i < 8) begin
        send(rand_instr(4 + i % 2, r), $random(seed) & PC_MASK, 0);
      end else begin
        send(b_type(r[12:0], r[24:20], r[19:15], (k < 2) ? k : k + 2),
             $random(seed) & PC_MASK, 0);
      end
    end
    close_test("control", start);

    // Loads, stores, unknown opcodes and bad funct7
    start = errors;
    for (int i = 0; i < N_MEM; i++) begin
      r = $random(seed);
      case (i % 4)
        0:       opc = 7'h0f;
        1:       opc = 7'h73;
        2:       opc = 7'h7f;
        default: opc = 7'h00;
      endcase
      if (i < 8) begin
        send(i_type(r[31:20], r[19:15], 3'd2, r[11:7], 7'h03), $random(seed) & PC_MASK, 0);
      end else if (i < 16) begin
        send(s_type(r[31:20], r[24:20], r[19:15], 3'd2), $random(seed) & PC_MASK, 0);
      end else if (i < 20) begin
        send({r[31:7], opc}, $random(seed) & PC_MASK, 0);
      end else begin
        send(r_type(i[0] ? 7'h01 : 7'h20, r[24:20], r[19:15], i[1] ? 3'd1 : 3'd4, r[11:7]),
             $random(seed) & PC_MASK, 0);
      end
    end
    close_test("memory", start);

    // Random mix with input gaps and output stalls
    start = errors;
    preload_regs();
    mix_mode = 1'b1;
    for (int i = 0; i < N_MIX; i++) begin
      send(rand_instr($random(seed) & 7, $random(seed)), $random(seed) & PC_MASK,
           (($random(seed) & 3) == 3) ? 2 : 0);
    end
    close_test("mix", start);
    mix_mode = 1'b0;

    // Catch late duplicates
    repeat (4) @(negedge clk);
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
